// File: baton_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module baton_tracker #(
   parameter int unsigned STROKE_HYSTERESIS = 4
) (
   input  logic                     clk_camera,
   input  logic                     sys_rst_camera,
   input  logic                     measure_i,
   input  tracker_pkg::vcount_t     com_y_i,
   input  logic                     com_valid_i,
   output logic                     beat_o,
   output tracker_pkg::beat_count_t beat_count_o
);

   tracker_pkg::stroke_state_t state;
   // lowest point of a down-stroke, highest of an up-stroke
   tracker_pkg::vcount_t       extreme;

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         state        <= tracker_pkg::STROKE_IDLE;
         extreme      <= '0;
         beat_o       <= 1'b0;
         beat_count_o <= '0;
      end else begin
         beat_o <= 1'b0;
         if (!measure_i) begin
            // count holds while not measuring
            state <= tracker_pkg::STROKE_IDLE;
         end else if (com_valid_i) begin
            case (state)
               tracker_pkg::STROKE_IDLE: begin
                  extreme <= com_y_i;
                  state   <= tracker_pkg::STROKE_DOWN;
               end
               tracker_pkg::STROKE_DOWN: begin
                  // y grows downwards on the image
                  if (com_y_i > extreme) begin
                     extreme <= com_y_i;
                  end else if ((extreme - com_y_i) > STROKE_HYSTERESIS) begin
                     // bottom turn is the beat
                     beat_o       <= 1'b1;
                     beat_count_o <= beat_count_o + tracker_pkg::beat_count_t'(1);
                     extreme      <= com_y_i;
                     state        <= tracker_pkg::STROKE_UP;
                  end
               end
               tracker_pkg::STROKE_UP: begin
                  if (com_y_i < extreme) begin
                     extreme <= com_y_i;
                  end else if ((com_y_i - extreme) > STROKE_HYSTERESIS) begin
                     extreme <= com_y_i;
                     state   <= tracker_pkg::STROKE_DOWN;
                  end
               end
               default: state <= tracker_pkg::STROKE_IDLE;
            endcase
         end
      end
   end

   // centre arrives as a single-cycle strobe
   a_valid_pulse: assert property (@(posedge clk_camera) disable iff (sys_rst_camera)
      com_valid_i |=> !com_valid_i);

endmodule

`default_nettype wire

// File: baton_tracker_top.sv
`timescale 1ns/10ps
`default_nettype none

module baton_tracker_top #(
   parameter int unsigned          FRAME_WIDTH       = 320,
   parameter int unsigned          FRAME_HEIGHT      = 180,
   parameter tracker_pkg::chroma_t CHROMA_LOWER      = 8'd160,
   parameter tracker_pkg::chroma_t CHROMA_UPPER      = 8'd240,
   parameter int unsigned          STROKE_HYSTERESIS = 4
) (
   input  logic                     clk_camera,
   input  logic                     sys_rst_camera,
   input  tracker_pkg::cam_byte_t   cam_data_i,
   input  logic                     cam_pclk_i,
   input  logic                     cam_hsync_i,
   input  logic                     cam_vsync_i,
   input  logic                     measure_i,
   output tracker_pkg::hcount_t     com_x_o,
   output tracker_pkg::vcount_t     com_y_o,
   output logic                     com_valid_o,
   output logic                     beat_o,
   output tracker_pkg::beat_count_t beat_count_o
);

   pixel_bus_if pix_bus ();
   mask_bus_if  mask_bus ();

   // camera pins to rgb565 pixels
   pixel_reconstruct #(
      .FRAME_WIDTH  (FRAME_WIDTH),
      .FRAME_HEIGHT (FRAME_HEIGHT)
   ) i_pixel_reconstruct (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .cam_data_i     (cam_data_i),
      .cam_pclk_i     (cam_pclk_i),
      .cam_hsync_i    (cam_hsync_i),
      .cam_vsync_i    (cam_vsync_i),
      .pix_o          (pix_bus.source)
   );

   // pink pixel mask
   color_threshold #(
      .CHROMA_LOWER (CHROMA_LOWER),
      .CHROMA_UPPER (CHROMA_UPPER)
   ) i_color_threshold (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .pix_i          (pix_bus.sink),
      .mask_o         (mask_bus.source)
   );

   // centre feeds both the outputs and the tracker
   center_of_mass #(
      .FRAME_WIDTH  (FRAME_WIDTH),
      .FRAME_HEIGHT (FRAME_HEIGHT)
   ) i_center_of_mass (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .mask_i         (mask_bus.sink),
      .com_x_o        (com_x_o),
      .com_y_o        (com_y_o),
      .com_valid_o    (com_valid_o)
   );

   baton_tracker #(
      .STROKE_HYSTERESIS (STROKE_HYSTERESIS)
   ) i_baton_tracker (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .measure_i      (measure_i),
      .com_y_i        (com_y_o),
      .com_valid_i    (com_valid_o),
      .beat_o         (beat_o),
      .beat_count_o   (beat_count_o)
   );

endmodule

`default_nettype wire

// File: center_of_mass.sv
`timescale 1ns/10ps
`default_nettype none

module center_of_mass #(
   parameter int unsigned FRAME_WIDTH  = 320,
   parameter int unsigned FRAME_HEIGHT = 180
) (
   input  logic                  clk_camera,
   input  logic                  sys_rst_camera,
   mask_bus_if.sink              mask_i,
   output tracker_pkg::hcount_t  com_x_o,
   output tracker_pkg::vcount_t  com_y_o,
   output logic                  com_valid_o
);

   // one quotient bit per step, wide enough for the x sum
   localparam int DIV_STEPS = $bits(tracker_pkg::x_sum_t);
   localparam int REM_W     = $bits(tracker_pkg::pixel_count_t);
   localparam int STEP_W    = REM_W + DIV_STEPS;
   localparam int CNT_W     = $clog2(DIV_STEPS);

   // one restoring step, result is {remainder, quotient}
   function automatic logic [STEP_W-1:0] div_step(
      input tracker_pkg::pixel_count_t rem,
      input tracker_pkg::x_sum_t       quo,
      input tracker_pkg::pixel_count_t den
   );
      logic [REM_W:0]    trial;
      logic [STEP_W-1:0] res;
      trial = {rem, quo[DIV_STEPS-1]};
      if (trial >= {1'b0, den}) begin
         res = {REM_W'(trial - {1'b0, den}), quo[DIV_STEPS-2:0], 1'b1};
      end else begin
         res = {trial[REM_W-1:0], quo[DIV_STEPS-2:0], 1'b0};
      end
      return res;
   endfunction

   logic                      marked;
   logic                      frame_end;
   tracker_pkg::x_sum_t       x_sum;
   tracker_pkg::y_sum_t       y_sum;
   tracker_pkg::pixel_count_t count;
   tracker_pkg::x_sum_t       x_sum_next;
   tracker_pkg::y_sum_t       y_sum_next;
   tracker_pkg::pixel_count_t count_next;

   // divider state, y runs on the x width
   logic                      busy;
   logic [CNT_W-1:0]          step;
   tracker_pkg::pixel_count_t den;
   tracker_pkg::pixel_count_t x_rem;
   tracker_pkg::pixel_count_t y_rem;
   tracker_pkg::x_sum_t       x_quo;
   tracker_pkg::x_sum_t       y_quo;
   logic [STEP_W-1:0]         x_res;
   logic [STEP_W-1:0]         y_res;

   assign marked    = mask_i.valid & mask_i.mask;
   assign frame_end = mask_i.valid
                      && (mask_i.hcount == tracker_pkg::hcount_t'(FRAME_WIDTH - 1))
                      && (mask_i.vcount == tracker_pkg::vcount_t'(FRAME_HEIGHT - 1));

   // sums including the current pixel, so the last one counts
   always_comb begin
      x_sum_next = x_sum + (marked ? tracker_pkg::x_sum_t'(mask_i.hcount) : '0);
      y_sum_next = y_sum + (marked ? tracker_pkg::y_sum_t'(mask_i.vcount) : '0);
      count_next = count + tracker_pkg::pixel_count_t'(marked);
   end

   assign x_res = div_step(x_rem, x_quo, den);
   assign y_res = div_step(y_rem, y_quo, den);

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         x_sum       <= '0;
         y_sum       <= '0;
         count       <= '0;
         busy        <= 1'b0;
         step        <= '0;
         com_valid_o <= 1'b0;
         com_x_o     <= '0;
         com_y_o     <= '0;
      end else begin
         com_valid_o <= 1'b0;
         if (frame_end) begin
            // hand the frame to the divider, start the next one empty
            x_sum <= '0;
            y_sum <= '0;
            count <= '0;
            x_quo <= x_sum_next;
            y_quo <= tracker_pkg::x_sum_t'(y_sum_next);
            x_rem <= '0;
            y_rem <= '0;
            den   <= count_next;
            step  <= '0;
            // empty frame keeps the old centre
            busy  <= (count_next != '0);
         end else begin
            x_sum <= x_sum_next;
            y_sum <= y_sum_next;
            count <= count_next;
         end
         if (busy) begin
            {x_rem, x_quo} <= x_res;
            {y_rem, y_quo} <= y_res;
            step           <= step + CNT_W'(1);
            if (step == CNT_W'(DIV_STEPS - 1)) begin
               busy        <= 1'b0;
               com_valid_o <= 1'b1;
               // mean fits the position width, low quotient bits
               com_x_o     <= tracker_pkg::hcount_t'(x_res);
               com_y_o     <= tracker_pkg::vcount_t'(y_res);
            end
         end
      end
   end

   // a frame is much longer than the division
   a_no_overlap: assert property (@(posedge clk_camera) disable iff (sys_rst_camera)
      frame_end |-> !busy);

endmodule

`default_nettype wire

// File: color_threshold.sv
`timescale 1ns/10ps
`default_nettype none

module color_threshold #(
   parameter tracker_pkg::chroma_t CHROMA_LOWER = 8'd160,
   parameter tracker_pkg::chroma_t CHROMA_UPPER = 8'd240
) (
   input  logic       clk_camera,
   input  logic       sys_rst_camera,
   pixel_bus_if.sink  pix_i,
   mask_bus_if.source mask_o
);

   // channels widened to 8 bits
   tracker_pkg::chroma_t red8;
   tracker_pkg::chroma_t green8;
   tracker_pkg::chroma_t chroma;
   logic                 in_range;

   always_comb begin
      red8   = {pix_i.data[15:11], 3'b000};
      green8 = {pix_i.data[10:5], 2'b00};
      // red dominance, floored at zero
      chroma = (red8 > green8) ? (red8 - green8) : '0;
      // both bounds inclusive
      in_range = (chroma >= CHROMA_LOWER) && (chroma <= CHROMA_UPPER);
   end

   // strobe alone carries reset
   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         mask_o.valid <= 1'b0;
      end else begin
         mask_o.valid <= pix_i.valid;
      end
   end

   // position follows the pixel through the stage
   always_ff @(posedge clk_camera) begin
      mask_o.mask   <= in_range;
      mask_o.hcount <= pix_i.hcount;
      mask_o.vcount <= pix_i.vcount;
   end

endmodule

`default_nettype wire

// File: list.f
tracker_pkg.sv
tracker_ifs.sv
pixel_reconstruct.sv
color_threshold.sv
center_of_mass.sv
baton_tracker.sv
baton_tracker_top.sv
tb_baton_tracker_top.sv

// File: pixel_reconstruct.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_reconstruct #(
   parameter int unsigned FRAME_WIDTH  = 320,
   parameter int unsigned FRAME_HEIGHT = 180
) (
   input  logic                  clk_camera,
   input  logic                  sys_rst_camera,
   input  tracker_pkg::cam_byte_t cam_data_i,
   input  logic                  cam_pclk_i,
   input  logic                  cam_hsync_i,
   input  logic                  cam_vsync_i,
   pixel_bus_if.source           pix_o
);

   localparam int LAST = tracker_pkg::SYNC_STAGES - 1;

   // synchronizer chains, last stage is the usable one
   logic [LAST:0]          pclk_sync;
   logic [LAST:0]          hsync_sync;
   logic [LAST:0]          vsync_sync;
   tracker_pkg::cam_byte_t data_sync [tracker_pkg::SYNC_STAGES];

   // previous synced levels for edge detect
   logic pclk_d;
   logic hsync_d;
   logic pclk_rise;
   logic hsync_fall;

   // byte pairing and position
   logic                   byte_phase;
   tracker_pkg::cam_byte_t high_byte;
   tracker_pkg::hcount_t   hcount;
   tracker_pkg::vcount_t   vcount;

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         pclk_sync  <= '0;
         hsync_sync <= '0;
         vsync_sync <= '0;
         pclk_d     <= 1'b0;
         hsync_d    <= 1'b0;
      end else begin
         pclk_sync  <= {pclk_sync[LAST-1:0], cam_pclk_i};
         hsync_sync <= {hsync_sync[LAST-1:0], cam_hsync_i};
         vsync_sync <= {vsync_sync[LAST-1:0], cam_vsync_i};
         pclk_d     <= pclk_sync[LAST];
         hsync_d    <= hsync_sync[LAST];
      end
   end

   // data rides alongside pclk so the byte lines up with its edge
   always_ff @(posedge clk_camera) begin
      data_sync[0] <= cam_data_i;
      for (int i = 1; i < tracker_pkg::SYNC_STAGES; i++) begin
         data_sync[i] <= data_sync[i-1];
      end
   end

   assign pclk_rise  = pclk_sync[LAST] & ~pclk_d;
   assign hsync_fall = ~hsync_sync[LAST] & hsync_d;

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         byte_phase  <= 1'b0;
         hcount      <= '0;
         vcount      <= '0;
         pix_o.valid <= 1'b0;
      end else begin
         pix_o.valid <= 1'b0;
         // vsync wins over everything, new frame
         if (vsync_sync[LAST]) begin
            byte_phase <= 1'b0;
            hcount     <= '0;
            vcount     <= '0;
         end else if (hsync_fall) begin
            byte_phase <= 1'b0;
            hcount     <= '0;
            vcount     <= vcount + tracker_pkg::vcount_t'(1);
         end else if (pclk_rise && hsync_sync[LAST]) begin
            byte_phase <= ~byte_phase;
            if (!byte_phase) begin
               // high half first
               high_byte <= data_sync[LAST];
            end else begin
               pix_o.valid  <= 1'b1;
               pix_o.data   <= {high_byte, data_sync[LAST]};
               pix_o.hcount <= hcount;
               pix_o.vcount <= vcount;
               hcount       <= hcount + tracker_pkg::hcount_t'(1);
            end
         end
      end
   end

   // camera must not deliver more pixels than the frame holds
   a_pix_in_frame: assert property (@(posedge clk_camera) disable iff (sys_rst_camera)
      pix_o.valid |-> (pix_o.hcount < FRAME_WIDTH && pix_o.vcount < FRAME_HEIGHT));

endmodule

`default_nettype wire

// File: tb_baton_tracker_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_baton_tracker_top;

   localparam int FRAME_WIDTH   = 32;
   localparam int FRAME_HEIGHT  = 18;
   localparam int HYSTERESIS    = 4;
   localparam int VALID_TIMEOUT = 200;
   // quiet window for frames without pink, well past the divider latency
   localparam int QUIET_CYCLES  = 80;
   // chroma 248, above the upper bound
   localparam logic [15:0] DECOY_COLOUR = 16'hF81F;
   localparam int M_IDLE = 0;
   localparam int M_DOWN = 1;
   localparam int M_UP   = 2;

   // one frame: pink rectangle, decoy rectangle, measure level
   typedef struct packed {
      logic [7:0]  x0;
      logic [7:0]  y0;
      logic [7:0]  w;
      logic [7:0]  h;
      logic [15:0] colour;
      logic [7:0]  dx0;
      logic [7:0]  dy0;
      logic [7:0]  dw;
      logic [7:0]  dh;
      logic        measure;
   } frame_row_t;

   logic                     clk_camera;
   logic                     sys_rst_camera;
   tracker_pkg::cam_byte_t   cam_data_i;
   logic                     cam_pclk_i;
   logic                     cam_hsync_i;
   logic                     cam_vsync_i;
   logic                     measure_i;
   tracker_pkg::hcount_t     com_x_o;
   tracker_pkg::vcount_t     com_y_o;
   logic                     com_valid_o;
   logic                     beat_o;
   tracker_pkg::beat_count_t beat_count_o;

   int         valid_seen = 0;
   int         beat_seen = 0;
   frame_row_t rows [$];
   // stroke model state
   int         m_state = M_IDLE;
   int         m_extreme = 0;
   int         m_beats = 0;

   baton_tracker_top #(
      .FRAME_WIDTH       (FRAME_WIDTH),
      .FRAME_HEIGHT      (FRAME_HEIGHT),
      .STROKE_HYSTERESIS (HYSTERESIS)
   ) i_baton_tracker_top (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .cam_data_i     (cam_data_i),
      .cam_pclk_i     (cam_pclk_i),
      .cam_hsync_i    (cam_hsync_i),
      .cam_vsync_i    (cam_vsync_i),
      .measure_i      (measure_i),
      .com_x_o        (com_x_o),
      .com_y_o        (com_y_o),
      .com_valid_o    (com_valid_o),
      .beat_o         (beat_o),
      .beat_count_o   (beat_count_o)
   );

   initial begin
      clk_camera = 1'b0;
      forever #20 clk_camera = ~clk_camera;
   end

   // strobes counted mid-cycle, away from the active edge
   always @(negedge clk_camera) begin
      if (com_valid_o) valid_seen++;
      if (beat_o) beat_seen++;
   end

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("Something failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         stop_on_error($sformatf("mismatch %s: got %h, expected %h", name, actual, expected));
      end
   endtask

   // inputs move 2 ns after each rising edge
   task automatic step_cycles(input int n);
      repeat (n) begin
         @(posedge clk_camera);
         #2;
      end
   endtask

   function automatic frame_row_t make_row(input int x0, input int y0, input int w,
                                           input int h, input logic [15:0] colour,
                                           input int dx0, input int dy0, input int dw,
                                           input int dh, input logic measure);
      frame_row_t r;
      r = '{x0, y0, w, h, colour, dx0, dy0, dw, dh, measure};
      return r;
   endfunction

   // red kept below 16 of 32, so chroma never reaches the lower bound
   function automatic logic [15:0] background_colour();
      logic [15:0] v;
      v = 16'($urandom());
      v[15] = 1'b0;
      return v;
   endfunction

   // pclk high 2 cycles, low 2 cycles per byte
   task automatic send_byte(input tracker_pkg::cam_byte_t b);
      cam_data_i = b;
      cam_pclk_i = 1'b1;
      step_cycles(2);
      cam_pclk_i = 1'b0;
      step_cycles(2);
   endtask

   // drives one frame and returns the sums of the pink pixels it sent
   task automatic send_frame(input frame_row_t row, output int sx, output int sy,
                             output int cnt);
      logic [15:0] px;
      sx = 0;
      sy = 0;
      cnt = 0;
      cam_vsync_i = 1'b1;
      step_cycles(4);
      cam_vsync_i = 1'b0;
      step_cycles(4);
      for (int y = 0; y < FRAME_HEIGHT; y++) begin
         cam_hsync_i = 1'b1;
         step_cycles(2);
         for (int x = 0; x < FRAME_WIDTH; x++) begin
            if (x >= row.x0 && x < row.x0 + row.w && y >= row.y0 && y < row.y0 + row.h) begin
               px = row.colour;
               sx += x;
               sy += y;
               cnt++;
            end else if (x >= row.dx0 && x < row.dx0 + row.dw &&
                         y >= row.dy0 && y < row.dy0 + row.dh) begin
               px = DECOY_COLOUR;
            end else begin
               px = background_colour();
            end
            // high half first
            send_byte(px[15:8]);
            send_byte(px[7:0]);
         end
         cam_hsync_i = 1'b0;
         step_cycles(4);
      end
   endtask

   task automatic wait_centre(input int target);
      int n;
      n = 0;
      while (valid_seen < target) begin
         if (n >= VALID_TIMEOUT) begin
            stop_on_error("timed out waiting for com_valid_o after the frame");
         end else begin
            step_cycles(1);
            n++;
         end
      end
   endtask

   // beat at the bottom turn, hysteresis strictly exceeded
   task automatic step_stroke_model(input int y, input logic measure, input logic has_centre);
      if (!measure) begin
         m_state = M_IDLE;
      end else if (has_centre) begin
         if (m_state == M_IDLE) begin
            m_extreme = y;
            m_state = M_DOWN;
         end else if (m_state == M_DOWN) begin
            if (y > m_extreme) begin
               m_extreme = y;
            end else if (m_extreme - y > HYSTERESIS) begin
               m_beats++;
               m_extreme = y;
               m_state = M_UP;
            end
         end else begin
            if (y < m_extreme) begin
               m_extreme = y;
            end else if (y - m_extreme > HYSTERESIS) begin
               m_extreme = y;
               m_state = M_DOWN;
            end
         end
      end
   endtask

   initial begin
      int sx;
      int sy;
      int cnt;
      int exp_x;
      int exp_y;
      int exp_valids;
      void'($urandom(32'h5ae4));
      exp_x = 0;
      exp_y = 0;
      exp_valids = 0;
      sys_rst_camera = 1'b1;
      cam_data_i = '0;
      cam_pclk_i = 1'b0;
      cam_hsync_i = 1'b0;
      cam_vsync_i = 1'b0;
      measure_i = 1'b0;

      // threshold frames, an empty one, then strokes measured and unmeasured
      rows.push_back(make_row(4, 2, 6, 4, 16'hFA14, 0, 0, 0, 0, 1'b1));
      rows.push_back(make_row(20, 10, 4, 3, 16'hA000, 2, 2, 6, 6, 1'b1));
      rows.push_back(make_row(0, 0, 0, 0, 16'hFA14, 2, 2, 6, 6, 1'b1));
      rows.push_back(make_row(10, 14, 5, 3, 16'hFA14, 0, 0, 0, 0, 1'b1));
      rows.push_back(make_row(10, 3, 5, 3, 16'hFA14, 0, 0, 0, 0, 1'b1));
      rows.push_back(make_row(10, 6, 5, 3, 16'hFA14, 0, 0, 0, 0, 1'b1));
      rows.push_back(make_row(10, 12, 5, 3, 16'hFA14, 0, 0, 0, 0, 1'b1));
      rows.push_back(make_row(10, 10, 5, 3, 16'hFA14, 0, 0, 0, 0, 1'b1));
      rows.push_back(make_row(10, 2, 5, 3, 16'hFA14, 0, 0, 0, 0, 1'b1));
      rows.push_back(make_row(10, 14, 5, 3, 16'hFA14, 0, 0, 0, 0, 1'b0));
      rows.push_back(make_row(10, 2, 5, 3, 16'hFA14, 0, 0, 0, 0, 1'b0));
      rows.push_back(make_row(10, 14, 5, 3, 16'hFA14, 0, 0, 0, 0, 1'b0));
      rows.push_back(make_row(10, 2, 5, 3, 16'hFA14, 0, 0, 0, 0, 1'b0));

      step_cycles(4);
      sys_rst_camera = 1'b0;
      step_cycles(8);
      check_value("com_valid_o count", valid_seen, 0);
      check_value("beat_o count", beat_seen, 0);
      check_value("com_x_o", com_x_o, 0);
      check_value("com_y_o", com_y_o, 0);
      check_value("beat_count_o", beat_count_o, 0);

      for (int r = 0; r < rows.size(); r++) begin
         measure_i = rows[r].measure;
         send_frame(rows[r], sx, sy, cnt);
         if (cnt > 0) begin
            exp_x = sx / cnt;
            exp_y = sy / cnt;
            exp_valids++;
            wait_centre(exp_valids);
            // beat lands one cycle after the centre
            step_cycles(2);
         end else begin
            step_cycles(QUIET_CYCLES);
         end
         step_stroke_model(exp_y, rows[r].measure, cnt > 0);
         check_value("com_valid_o count", valid_seen, exp_valids);
         check_value("com_x_o", com_x_o, exp_x);
         check_value("com_y_o", com_y_o, exp_y);
         check_value("beat_o count", beat_seen, m_beats);
         check_value("beat_count_o", beat_count_o, m_beats & 8'hFF);
      end

      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

// File: tracker_ifs.sv
`timescale 1ns/10ps
`default_nettype none

// reconstructed pixels with their position
interface pixel_bus_if;
   // one-cycle strobe, fields below only meaningful with it
   logic                 valid;
   tracker_pkg::pixel_t  data;
   tracker_pkg::hcount_t hcount;
   tracker_pkg::vcount_t vcount;

   modport source (output valid, output data, output hcount, output vcount);
   modport sink   (input valid, input data, input hcount, input vcount);
endinterface

// every pixel passes, mask marks the pink ones
interface mask_bus_if;
   logic                 valid;
   logic                 mask;
   tracker_pkg::hcount_t hcount;
   tracker_pkg::vcount_t vcount;

   modport source (output valid, output mask, output hcount, output vcount);
   modport sink   (input valid, input mask, input hcount, input vcount);
endinterface

`default_nettype wire

// File: tracker_pkg.sv
`default_nettype none

package tracker_pkg;

   // one byte of the camera data bus
   typedef logic [7:0] cam_byte_t;

   // rgb565 pixel, red in [15:11], green in [10:5], blue in [4:0]
   typedef logic [15:0] pixel_t;

   // frame position, sized for 320 x 180
   typedef logic [8:0] hcount_t;
   typedef logic [7:0] vcount_t;

   // red dominance and its bounds
   typedef logic [7:0] chroma_t;

   // centre of mass accumulators
   typedef logic [15:0] pixel_count_t;
   typedef logic [24:0] x_sum_t;
   typedef logic [23:0] y_sum_t;

   // wraps after 255 beats
   typedef logic [7:0] beat_count_t;

   // baton stroke direction
   typedef enum logic [1:0] {
      STROKE_IDLE = 2'd0,
      STROKE_DOWN = 2'd1,
      STROKE_UP   = 2'd2
   } stroke_state_t;

   // flops on each camera pin
   localparam int SYNC_STAGES = 2;

endpackage

`default_nettype wire
